// File: csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // exception and mode CSRs
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECTL   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;

    // timer CSRs
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_CNTC   = 14'h043;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // performance counters
    localparam csr_addr_t PMU_ICACHE_REQ  = 14'h0f00;
    localparam csr_addr_t PMU_ICACHE_MISS = 14'h0f01;
    localparam csr_addr_t PMU_DCACHE_REQ  = 14'h0f02;
    localparam csr_addr_t PMU_DCACHE_MISS = 14'h0f03;
    localparam csr_addr_t PMU_BPU_BRANCH  = 14'h0f04;
    localparam csr_addr_t PMU_BPU_MISS    = 14'h0f05;
    localparam csr_addr_t PMU_TLB_REQ     = 14'h0f06;
    localparam csr_addr_t PMU_TLB_MISS    = 14'h0f07;
    localparam csr_addr_t PMU_REFILL_CYC  = 14'h0f08;

    localparam int PMU_NUM = 9;
    // index i here is counter i in csr_perf_counters
    localparam csr_addr_t PMU_ADDR [PMU_NUM] = '{
        PMU_ICACHE_REQ, PMU_ICACHE_MISS, PMU_DCACHE_REQ, PMU_DCACHE_MISS,
        PMU_BPU_BRANCH, PMU_BPU_MISS, PMU_TLB_REQ, PMU_TLB_MISS, PMU_REFILL_CYC
    };

    // field positions, lsb of each field
    localparam int CRMD_PLV       = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int PRMD_PPLV      = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ECTL_LIE       = 0;
    localparam int ESTAT_IS       = 0;
    localparam int ESTAT_HWI      = 2;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL   = 2;
    localparam int TICLR_CLR      = 0;
    localparam int EENTRY_VA      = 6;

    // field widths
    localparam int PLV_W      = 2;
    localparam int IS_W       = 13;
    localparam int SWI_W      = 2;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    localparam int IRQ_HW_W    = 9;
    localparam int TIMER_SHIFT = 2;

    // writable bits
    localparam csr_data_t CRMD_WMASK = 32'h0000_01ff;
    localparam csr_data_t PRMD_WMASK = 32'h0000_0007;
    localparam csr_data_t ECTL_WMASK = 32'h0000_1fff;

    // DA set, everything else clear
    localparam csr_data_t CRMD_RESET = csr_data_t'(1) << CRMD_DA;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    typedef struct packed {
        logic                  excp_flush;
        logic                  ertn_flush;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        csr_data_t             era;
        logic                  va_error;
        csr_data_t             bad_va;
    } csr_excp_t;

    typedef struct packed {
        logic icache_req;
        logic icache_miss;
        logic dcache_req;
        logic dcache_miss;
        logic bpu_branch;
        logic bpu_miss;
        logic tlb_req;
        logic tlb_miss;
        logic refill_start;
    } pmu_event_t;

    function automatic logic wr_hit(csr_write_t wr, csr_addr_t addr);
        return wr.we && (wr.addr == addr);
    endfunction

    // countdown start value taken from a TCFG word
    function automatic csr_data_t tval_load(csr_data_t tcfg);
        return csr_data_t'(tcfg[31:TCFG_INITVAL]) << TIMER_SHIFT;
    endfunction

endpackage

// File: csr_excp_regs.sv
`timescale 1ns/10ps

module csr_excp_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  csr_pkg::csr_write_t           wr_i,
    input  csr_pkg::csr_excp_t            excp_i,
    input  logic [csr_pkg::IRQ_HW_W-1:0]  interrupt_i,
    input  logic                          timer_irq_i,
    input  csr_pkg::csr_addr_t            raddr_i,
    output csr_pkg::csr_data_t            rdata_o,
    output logic [1:0]                    plv_o,
    output logic                          has_int_o,
    output csr_pkg::csr_data_t            eentry_o,
    output csr_pkg::csr_data_t            era_o
);
    import csr_pkg::*;

    csr_data_t             crmd_q;
    csr_data_t             prmd_q;
    csr_data_t             ectl_q;
    logic [SWI_W-1:0]      estat_swi_q;
    logic [IRQ_HW_W-1:0]   estat_hwi_q;
    logic [ECODE_W-1:0]    estat_ecode_q;
    logic [ESUBCODE_W-1:0] estat_esubcode_q;
    csr_data_t             estat;
    csr_data_t             era_q;
    csr_data_t             badv_q;
    logic [31:EENTRY_VA]   eentry_q;
    csr_data_t             save_q [4];

    logic       wr_crmd;
    logic       wr_prmd;
    logic       wr_ectl;
    logic       wr_estat;
    logic       wr_era;
    logic       wr_badv;
    logic       wr_eentry;
    logic [3:0] wr_save;

    assign wr_crmd   = wr_hit(wr_i, CSR_CRMD);
    assign wr_prmd   = wr_hit(wr_i, CSR_PRMD);
    assign wr_ectl   = wr_hit(wr_i, CSR_ECTL);
    assign wr_estat  = wr_hit(wr_i, CSR_ESTAT);
    assign wr_era    = wr_hit(wr_i, CSR_ERA);
    assign wr_badv   = wr_hit(wr_i, CSR_BADV);
    assign wr_eentry = wr_hit(wr_i, CSR_EENTRY);
    assign wr_save   = {wr_hit(wr_i, CSR_SAVE3), wr_hit(wr_i, CSR_SAVE2),
                        wr_hit(wr_i, CSR_SAVE1), wr_hit(wr_i, CSR_SAVE0)};

    // entry clears PLV/IE, return restores them from PRMD
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crmd_q <= CRMD_RESET;
        end else if (excp_i.excp_flush) begin
            crmd_q[CRMD_PLV +: PLV_W] <= '0;
            crmd_q[CRMD_IE]           <= 1'b0;
        end else if (excp_i.ertn_flush) begin
            crmd_q[CRMD_PLV +: PLV_W] <= prmd_q[PRMD_PPLV +: PLV_W];
            crmd_q[CRMD_IE]           <= prmd_q[PRMD_PIE];
        end else if (wr_crmd) begin
            crmd_q <= wr_i.data & CRMD_WMASK;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prmd_q <= '0;
        end else if (excp_i.excp_flush) begin
            prmd_q[PRMD_PPLV +: PLV_W] <= crmd_q[CRMD_PLV +: PLV_W];
            prmd_q[PRMD_PIE]           <= crmd_q[CRMD_IE];
        end else if (wr_prmd) begin
            prmd_q <= wr_i.data & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ectl_q <= '0;
        end else if (wr_ectl) begin
            ectl_q <= wr_i.data & ECTL_WMASK;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            estat_swi_q      <= '0;
            estat_hwi_q      <= '0;
            estat_ecode_q    <= '0;
            estat_esubcode_q <= '0;
        end else begin
            // hw lines sampled every cycle
            estat_hwi_q <= interrupt_i;
            if (excp_i.excp_flush) begin
                estat_ecode_q    <= excp_i.ecode;
                estat_esubcode_q <= excp_i.esubcode;
            end else if (wr_estat) begin
                estat_swi_q <= wr_i.data[ESTAT_IS +: SWI_W];
            end
        end
    end

    // TI comes straight from the timer's own flop
    always_comb begin
        estat                                 = '0;
        estat[ESTAT_IS +: SWI_W]              = estat_swi_q;
        estat[ESTAT_HWI +: IRQ_HW_W]          = estat_hwi_q;
        estat[ESTAT_TI]                       = timer_irq_i;
        estat[ESTAT_ECODE +: ECODE_W]         = estat_ecode_q;
        estat[ESTAT_ESUBCODE +: ESUBCODE_W]   = estat_esubcode_q;
    end

    always_ff @(posedge clk_i) begin
        if (excp_i.excp_flush) begin
            era_q <= excp_i.era;
        end else if (wr_era) begin
            era_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_badv) begin
            badv_q <= wr_i.data;
        end else if (excp_i.va_error) begin
            badv_q <= excp_i.bad_va;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_eentry) begin
            eentry_q <= wr_i.data[31:EENTRY_VA];
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_save[i]) begin
                save_q[i] <= wr_i.data;
            end
        end
    end

    // privilege seen by fetch in the flush cycle itself
    always_comb begin
        if (excp_i.excp_flush) begin
            plv_o = '0;
        end else if (excp_i.ertn_flush) begin
            plv_o = prmd_q[PRMD_PPLV +: PLV_W];
        end else begin
            plv_o = crmd_q[CRMD_PLV +: PLV_W];
        end
    end

    assign has_int_o = crmd_q[CRMD_IE] &&
                       ((ectl_q[ECTL_LIE +: IS_W] & estat[ESTAT_IS +: IS_W]) != '0);

    assign eentry_o = {eentry_q, {EENTRY_VA{1'b0}}};
    assign era_o    = era_q;

    always_comb begin
        case (raddr_i)
            CSR_CRMD:   rdata_o = crmd_q;
            CSR_PRMD:   rdata_o = prmd_q;
            CSR_ECTL:   rdata_o = ectl_q;
            CSR_ESTAT:  rdata_o = estat;
            CSR_ERA:    rdata_o = era_q;
            CSR_BADV:   rdata_o = badv_q;
            CSR_EENTRY: rdata_o = eentry_o;
            CSR_SAVE0:  rdata_o = save_q[0];
            CSR_SAVE1:  rdata_o = save_q[1];
            CSR_SAVE2:  rdata_o = save_q[2];
            CSR_SAVE3:  rdata_o = save_q[3];
            default:    rdata_o = '0;
        endcase
    end

    // entry and return come from different pipeline events
    flush_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(excp_i.excp_flush && excp_i.ertn_flush));

endmodule

// File: csr_timer.sv
`timescale 1ns/10ps

module csr_timer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  csr_pkg::csr_write_t wr_i,
    input  csr_pkg::csr_addr_t  raddr_i,
    output csr_pkg::csr_data_t  rdata_o,
    output logic                timer_irq_o,
    output logic [63:0]         timer_64_o,
    output csr_pkg::csr_data_t  tid_o
);
    import csr_pkg::*;

    csr_data_t   tid_q;
    csr_data_t   tcfg_q;
    csr_data_t   tval_q;
    csr_data_t   cntc_q;
    logic        timer_en_q;
    logic        ti_q;
    logic [63:0] stable_cnt_q;

    logic wr_tcfg;
    logic ti_clr;
    logic expire;

    assign wr_tcfg = wr_hit(wr_i, CSR_TCFG);
    assign ti_clr  = wr_hit(wr_i, CSR_TICLR) && wr_i.data[TICLR_CLR];
    // a TCFG write in the same cycle restarts instead
    assign expire  = timer_en_q && (tval_q == '0) && !wr_tcfg;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tid_q <= '0;
        end else if (wr_hit(wr_i, CSR_TID)) begin
            tid_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cntc_q <= '0;
        end else if (wr_hit(wr_i, CSR_CNTC)) begin
            cntc_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tcfg_q <= '0;
        end else if (wr_tcfg) begin
            tcfg_q <= wr_i.data;
        end
    end

    // countdown; one-shot parks at all ones and stops
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tval_q     <= '0;
            timer_en_q <= 1'b0;
        end else if (wr_tcfg) begin
            tval_q     <= tval_load(wr_i.data);
            timer_en_q <= wr_i.data[TCFG_EN];
        end else if (expire) begin
            tval_q     <= tcfg_q[TCFG_PERIODIC] ? tval_load(tcfg_q) : '1;
            timer_en_q <= tcfg_q[TCFG_PERIODIC];
        end else if (timer_en_q) begin
            tval_q <= tval_q - 32'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ti_q <= 1'b0;
        end else if (ti_clr) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stable_cnt_q <= '0;
        end else begin
            stable_cnt_q <= stable_cnt_q + 64'd1;
        end
    end

    assign timer_irq_o = ti_q;
    assign tid_o       = tid_q;
    // CNTC is a signed offset
    assign timer_64_o  = stable_cnt_q + {{32{cntc_q[31]}}, cntc_q};

    // TICLR is write-only and falls to the default
    always_comb begin
        case (raddr_i)
            CSR_TID:  rdata_o = tid_q;
            CSR_TCFG: rdata_o = tcfg_q;
            CSR_TVAL: rdata_o = tval_q;
            CSR_CNTC: rdata_o = cntc_q;
            default:  rdata_o = '0;
        endcase
    end

    tval_no_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        !(wr_tcfg || expire) |=> (tval_q <= $past(tval_q)));

endmodule

// File: csr_perf_counters.sv
`timescale 1ns/10ps

module csr_perf_counters (
    input  logic                clk_i,
    input  logic                rst_i,
    input  csr_pkg::pmu_event_t pmu_i,
    input  logic                ertn_i,
    input  csr_pkg::csr_addr_t  raddr_i,
    output csr_pkg::csr_data_t  rdata_o
);
    import csr_pkg::*;

    csr_data_t          cnt_q [PMU_NUM];
    logic [PMU_NUM-1:0] inc;
    logic               refilling_q;

    // bit order follows PMU_ADDR
    assign inc = {
        refilling_q,
        pmu_i.tlb_miss,
        pmu_i.tlb_req,
        pmu_i.bpu_miss,
        pmu_i.bpu_branch,
        pmu_i.dcache_miss,
        pmu_i.dcache_req,
        pmu_i.icache_miss,
        pmu_i.icache_req
    };

    // refill handler runs until its ertn
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            refilling_q <= 1'b0;
        end else if (pmu_i.refill_start) begin
            refilling_q <= 1'b1;
        end else if (ertn_i) begin
            refilling_q <= 1'b0;
        end
    end

    // free-running, wraps at 2^32
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < PMU_NUM; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < PMU_NUM; i++) begin
                cnt_q[i] <= cnt_q[i] + csr_data_t'(inc[i]);
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < PMU_NUM; i++) begin
            if (raddr_i == PMU_ADDR[i]) begin
                rdata_o = cnt_q[i];
            end
        end
    end

    // a new refill cannot begin while one is still open
    refill_not_nested: assert property (@(posedge clk_i) disable iff (rst_i)
        refilling_q && !ertn_i |-> !pmu_i.refill_start);

endmodule

// File: csr_file_top.sv
`timescale 1ns/10ps

module csr_file_top (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_pkg::csr_write_t           wr_port0_i,
    input  csr_pkg::csr_write_t           wr_port1_i,
    input  csr_pkg::csr_excp_t            excp_i,
    input  logic [csr_pkg::IRQ_HW_W-1:0]  interrupt_i,
    input  csr_pkg::pmu_event_t           pmu_i,
    input  csr_pkg::csr_addr_t            raddr_i,
    output csr_pkg::csr_data_t            rdata_o,
    output logic [1:0]                    plv_o,
    output logic                          has_int_o,
    output csr_pkg::csr_data_t            eentry_o,
    output csr_pkg::csr_data_t            era_o,
    output logic [63:0]                   timer_64_o,
    output csr_pkg::csr_data_t            tid_o
);
    import csr_pkg::*;

    csr_write_t sel_wr;
    csr_data_t  excp_rdata;
    csr_data_t  timer_rdata;
    csr_data_t  perf_rdata;
    logic       timer_irq;

    // port 0 wins
    always_comb begin
        if (wr_port0_i.we) begin
            sel_wr = wr_port0_i;
        end else if (wr_port1_i.we) begin
            sel_wr = wr_port1_i;
        end else begin
            sel_wr = '0;
        end
    end

    csr_excp_regs csr_excp_regs_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .wr_i        (sel_wr),
        .excp_i      (excp_i),
        .interrupt_i (interrupt_i),
        .timer_irq_i (timer_irq),
        .raddr_i     (raddr_i),
        .rdata_o     (excp_rdata),
        .plv_o       (plv_o),
        .has_int_o   (has_int_o),
        .eentry_o    (eentry_o),
        .era_o       (era_o)
    );

    csr_timer csr_timer_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .wr_i        (sel_wr),
        .raddr_i     (raddr_i),
        .rdata_o     (timer_rdata),
        .timer_irq_o (timer_irq),
        .timer_64_o  (timer_64_o),
        .tid_o       (tid_o)
    );

    csr_perf_counters csr_perf_counters_i (
        .clk_i   (clk),
        .rst_i   (rst),
        .pmu_i   (pmu_i),
        .ertn_i  (excp_i.ertn_flush),
        .raddr_i (raddr_i),
        .rdata_o (perf_rdata)
    );

    // groups return zero outside their own range
    assign rdata_o = excp_rdata | timer_rdata | perf_rdata;

    wr_ports_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(wr_port0_i.we && wr_port1_i.we));

endmodule

// File: tb_csr_file.sv
`timescale 1ns/10ps

module tb_csr_file;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RESET    = 17;
    localparam int NUM_ALL      = 23;
    localparam int PERF_CYCLES  = 200;
    // cycle budgets of reset, write, exception, interrupt, timer and counter tests
    localparam int CYCLE_BUDGET = RESET_CYCLES + 60 + 40 + 60 + 120 + PERF_CYCLES + 10;

    // registers with a reset value come first
    localparam csr_addr_t CHECK_ADDRS [NUM_ALL] = '{
        CSR_CRMD, CSR_PRMD, CSR_ECTL, CSR_ESTAT, CSR_TID, CSR_TCFG, CSR_CNTC, CSR_TICLR,
        PMU_ICACHE_REQ, PMU_ICACHE_MISS, PMU_DCACHE_REQ, PMU_DCACHE_MISS, PMU_BPU_BRANCH,
        PMU_BPU_MISS, PMU_TLB_REQ, PMU_TLB_MISS, PMU_REFILL_CYC,
        CSR_ERA, CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3
    };
    localparam csr_addr_t WR_ADDRS [10] = '{
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA,
        CSR_EENTRY, CSR_ECTL, CSR_PRMD, CSR_TID, CSR_CNTC
    };

    logic                clk;
    logic                rst;
    csr_write_t          wr_port0_i;
    csr_write_t          wr_port1_i;
    csr_excp_t           excp_i;
    logic [IRQ_HW_W-1:0] interrupt_i;
    pmu_event_t          pmu_i;
    csr_addr_t           raddr_i;
    csr_data_t           rdata_o;
    logic [1:0]          plv_o;
    logic                has_int_o;
    csr_data_t           eentry_o;
    csr_data_t           era_o;
    logic [63:0]         timer_64_o;
    csr_data_t           tid_o;

    // model state
    csr_data_t           m_crmd, m_prmd, m_ectl, m_era, m_eentry, m_tid, m_tcfg, m_cntc;
    csr_data_t           m_save [4];
    csr_data_t           m_cnt [PMU_NUM];
    logic [1:0]          m_swi;
    logic [IRQ_HW_W-1:0] m_hwi;
    logic [5:0]          m_ecode;
    logic [8:0]          m_esub;
    logic                m_ti;
    logic                m_refill;
    logic [63:0]         m_stable;
    logic [31:0]         lfsr;

    csr_file_top csr_file_top_i (
        .clk         (clk),
        .rst         (rst),
        .wr_port0_i  (wr_port0_i),
        .wr_port1_i  (wr_port1_i),
        .excp_i      (excp_i),
        .interrupt_i (interrupt_i),
        .pmu_i       (pmu_i),
        .raddr_i     (raddr_i),
        .rdata_o     (rdata_o),
        .plv_o       (plv_o),
        .has_int_o   (has_int_o),
        .eentry_o    (eentry_o),
        .era_o       (era_o),
        .timer_64_o  (timer_64_o),
        .tid_o       (tid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic writes_to(csr_write_t w, csr_addr_t a);
        return w.we && (w.addr == a);
    endfunction

    // expected read value of one CSR
    function automatic csr_data_t exp_csr(csr_addr_t a);
        csr_data_t e;
        e = '0;
        case (a)
            CSR_CRMD:   e = m_crmd;
            CSR_PRMD:   e = m_prmd;
            CSR_ECTL:   e = m_ectl;
            CSR_ESTAT: begin
                e[1:0]   = m_swi;
                e[10:2]  = m_hwi;
                e[11]    = m_ti;
                e[21:16] = m_ecode;
                e[30:22] = m_esub;
            end
            CSR_ERA:    e = m_era;
            CSR_EENTRY: e = m_eentry;
            CSR_SAVE0:  e = m_save[0];
            CSR_SAVE1:  e = m_save[1];
            CSR_SAVE2:  e = m_save[2];
            CSR_SAVE3:  e = m_save[3];
            CSR_TID:    e = m_tid;
            CSR_TCFG:   e = m_tcfg;
            CSR_CNTC:   e = m_cntc;
            default: begin
                for (int i = 0; i < PMU_NUM; i++) begin
                    if (a == PMU_ADDR[i]) begin
                        e = m_cnt[i];
                    end
                end
            end
        endcase
        return e;
    endfunction

    function automatic logic exp_has_int();
        csr_data_t e;
        e = exp_csr(CSR_ESTAT);
        return m_crmd[2] && ((m_ectl[12:0] & e[12:0]) != 13'd0);
    endfunction

    function automatic logic [1:0] exp_plv();
        if (excp_i.excp_flush) begin
            return 2'b00;
        end else if (excp_i.ertn_flush) begin
            return m_prmd[1:0];
        end
        return m_crmd[1:0];
    endfunction

    task automatic abort(string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_data(string what, csr_data_t got, csr_data_t exp);
        if (got !== exp) begin
            abort($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            abort($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_timer64(logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            abort($sformatf("CHECK FAILED at %0t: timer_64_o got %h expected %h",
                            $time, got, exp));
        end
    endtask

    // model state after one rising edge
    task automatic update_model();
        csr_write_t w;
        csr_data_t  old_crmd;
        csr_data_t  old_prmd;
        logic [7:0] ev;
        w = wr_port0_i.we ? wr_port0_i : (wr_port1_i.we ? wr_port1_i : '0);
        old_crmd = m_crmd;
        old_prmd = m_prmd;
        ev = {pmu_i.tlb_miss, pmu_i.tlb_req, pmu_i.bpu_miss, pmu_i.bpu_branch,
              pmu_i.dcache_miss, pmu_i.dcache_req, pmu_i.icache_miss, pmu_i.icache_req};
        if (rst) begin
            m_crmd   = 32'h8;
            m_prmd   = '0;
            m_ectl   = '0;
            m_tid    = '0;
            m_tcfg   = '0;
            m_cntc   = '0;
            m_swi    = '0;
            m_hwi    = '0;
            m_ecode  = '0;
            m_esub   = '0;
            m_ti     = 1'b0;
            m_refill = 1'b0;
            m_stable = '0;
            for (int i = 0; i < PMU_NUM; i++) m_cnt[i] = '0;
            return;
        end
        m_stable = m_stable + 64'd1;
        if (excp_i.excp_flush) begin
            m_crmd[2:0] = 3'b000;
            m_prmd[2:0] = old_crmd[2:0];
            m_ecode     = excp_i.ecode;
            m_esub      = excp_i.esubcode;
            m_era       = excp_i.era;
        end else begin
            if (excp_i.ertn_flush) m_crmd[2:0] = old_prmd[2:0];
            else if (writes_to(w, CSR_CRMD)) m_crmd = w.data & 32'h0000_01ff;
            if (writes_to(w, CSR_PRMD)) m_prmd = w.data & 32'h0000_0007;
            if (writes_to(w, CSR_ESTAT)) m_swi = w.data[1:0];
            if (writes_to(w, CSR_ERA)) m_era = w.data;
        end
        m_hwi = interrupt_i;
        if (writes_to(w, CSR_ECTL)) m_ectl = w.data & 32'h0000_1fff;
        if (writes_to(w, CSR_EENTRY)) m_eentry = w.data & 32'hffff_ffc0;
        for (int i = 0; i < 4; i++) begin
            if (writes_to(w, CSR_SAVE0 + csr_addr_t'(i))) m_save[i] = w.data;
        end
        if (writes_to(w, CSR_TID)) m_tid = w.data;
        if (writes_to(w, CSR_TCFG)) m_tcfg = w.data;
        if (writes_to(w, CSR_CNTC)) m_cntc = w.data;
        if (writes_to(w, CSR_TICLR) && w.data[0]) m_ti = 1'b0;
        for (int i = 0; i < 8; i++) m_cnt[i] = m_cnt[i] + 32'(ev[i]);
        m_cnt[8] = m_cnt[8] + 32'(m_refill);
        if (pmu_i.refill_start) m_refill = 1'b1;
        else if (excp_i.ertn_flush) m_refill = 1'b0;
    endtask

    task automatic tick();
        @(posedge clk);
        update_model();
        @(negedge clk);
    endtask

    task automatic write_csr(csr_addr_t a, csr_data_t d);
        if (rand_bits(1) == 32'd0) begin
            wr_port0_i = {1'b1, a, d};
        end else begin
            wr_port1_i = {1'b1, a, d};
        end
        tick();
        wr_port0_i = '0;
        wr_port1_i = '0;
    endtask

    task automatic read_check(csr_addr_t a, csr_data_t exp);
        raddr_i = a;
        #0.05;
        check_data($sformatf("read of CSR %h", a), rdata_o, exp);
    endtask

    // reads the first n CSRs of the list and the side outputs
    task automatic compare_all(int n);
        for (int i = 0; i < n; i++) begin
            read_check(CHECK_ADDRS[i], exp_csr(CHECK_ADDRS[i]));
        end
        check_bit("plv_o", plv_o, exp_plv());
        check_bit("has_int_o", {1'b0, has_int_o}, {1'b0, exp_has_int()});
        check_timer64(timer_64_o, m_stable + {{32{m_cntc[31]}}, m_cntc});
        check_data("tid_o", tid_o, m_tid);
        // era and eentry have no reset value
        if (n > NUM_RESET) begin
            check_data("eentry_o", eentry_o, m_eentry);
            check_data("era_o", era_o, m_era);
        end
    endtask

    task automatic run_timer(logic periodic);
        int n;
        n = 1 + int'(rand_bits(3));
        write_csr(CSR_TCFG, (csr_data_t'(n) << 2) | {30'd0, periodic, 1'b1});
        read_check(CSR_TVAL, csr_data_t'(4 * n));
        for (int k = 1; k <= 4 * n; k++) begin
            tick();
            read_check(CSR_TVAL, csr_data_t'(4 * n - k));
            read_check(CSR_ESTAT, exp_csr(CSR_ESTAT));
        end
        tick();
        m_ti = 1'b1;
        read_check(CSR_TVAL, periodic ? csr_data_t'(4 * n) : 32'hffff_ffff);
        compare_all(NUM_ALL);
        write_csr(CSR_TICLR, 32'd1);
        compare_all(NUM_ALL);
        if (periodic) begin
            // TI again after the reload
            repeat (4 * n - 1) tick();
            read_check(CSR_ESTAT, exp_csr(CSR_ESTAT));
            tick();
            m_ti = 1'b1;
            compare_all(NUM_ALL);
            write_csr(CSR_TCFG, 32'd0);
            write_csr(CSR_TICLR, 32'd1);
            compare_all(NUM_ALL);
        end
    endtask

    initial begin
        #(2 * CYCLE_BUDGET * CLK_PERIOD);
        abort("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        logic start;
        clk         = 1'b0;
        rst         = 1'b1;
        lfsr        = 32'h04a1e6cb;
        wr_port0_i  = '0;
        wr_port1_i  = '0;
        excp_i      = '0;
        interrupt_i = '0;
        pmu_i       = '0;
        raddr_i     = '0;
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        compare_all(NUM_RESET);

        for (int i = 0; i < 10; i++) write_csr(WR_ADDRS[i], rand_bits(32));
        repeat (40) write_csr(WR_ADDRS[int'(rand_bits(4) % 32'd10)], rand_bits(32));
        compare_all(NUM_ALL);

        repeat (8) begin
            write_csr(CSR_CRMD, rand_bits(32));
            write_csr(CSR_PRMD, rand_bits(32));
            excp_i.excp_flush = 1'b1;
            excp_i.ecode      = 6'(rand_bits(6));
            excp_i.esubcode   = 9'(rand_bits(9));
            excp_i.era        = rand_bits(32);
            #0.05;
            check_bit("plv_o during flush", plv_o, 2'b00);
            tick();
            excp_i = '0;
            compare_all(NUM_ALL);
            excp_i.ertn_flush = 1'b1;
            #0.05;
            check_bit("plv_o during return", plv_o, m_prmd[1:0]);
            tick();
            excp_i = '0;
            compare_all(NUM_ALL);
        end

        write_csr(CSR_ECTL, rand_bits(32));
        write_csr(CSR_CRMD, 32'h4);
        repeat (30) begin
            interrupt_i = 9'(rand_bits(9));
            if (rand_bits(2) == 32'd0) write_csr(CSR_ESTAT, rand_bits(32));
            else tick();
            check_bit("has_int_o", {1'b0, has_int_o}, {1'b0, exp_has_int()});
        end
        interrupt_i = '0;
        tick();

        run_timer(1'b0);
        run_timer(1'b1);

        repeat (PERF_CYCLES) begin
            start = !m_refill && (rand_bits(3) == 32'd0);
            pmu_i = pmu_event_t'({8'(rand_bits(8)), start});
            excp_i.ertn_flush = m_refill && !start && (rand_bits(3) == 32'd0);
            tick();
        end
        pmu_i = '0;
        excp_i = '0;
        compare_all(NUM_ALL);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: vlog.f
csr_pkg.sv
csr_excp_regs.sv
csr_timer.sv
csr_perf_counters.sv
csr_file_top.sv
tb_csr_file.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the CSR file testbench; exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_csr_file \
    -f vlog.f \
    -o sim_csr_file

./obj_dir/sim_csr_file
